//--- Bender.yml
package:
  name: slot_alloc

sources:
  - include_dirs:
      - .
    files:
      - alloc_pkg.sv
      - lzp.sv
      - req_sync_stage.sv
      - slot_pick_stage.sv
      - slot_table.sv
      - grant_stage.sv
      - slot_alloc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_slot_alloc.sv

//--- alloc_params.svh
/* Sizing macros for the tag allocator.
   Include ahead of the package and of every module that sizes slots or owners. */

`ifndef ALLOC_PARAMS_SVH
`define ALLOC_PARAMS_SVH

// Slot index width. lzp covers at most 128 bits, so this stays at 7 or below.
`define ALLOC_CW 4

// Pool size, one slot per index value.
`define ALLOC_SLOTS (1 << `ALLOC_CW)

// Owner id carried with each request.
`define ALLOC_OWNER_W 8

`endif

//--- alloc_pkg.sv
/* Shared types of the tag allocator.
   Modules import it with a wildcard in their header. */

`default_nettype none

`include "alloc_params.svh"

package alloc_pkg;

	typedef logic [`ALLOC_CW-1:0] slot_t;       // Index into the pool.
	typedef logic [`ALLOC_OWNER_W-1:0] owner_t; // Id of the requesting unit.

	// Request word from the host.
	typedef struct packed {
		owner_t owner;
	} alloc_req_t;

	// Grant word to the consumer.
	typedef struct packed {
		slot_t  slot;  // Slot handed out.
		owner_t owner; // Echo of the requester.
	} alloc_grant_t;

endpackage

`default_nettype wire

//--- grant_stage.sv
/* Four-phase master for the grant port.
   Holds one grant from acceptance until the consumer has dropped its ack. */

`timescale 1ns/1ps
`default_nettype none

`include "alloc_params.svh"

module grant_stage
	import alloc_pkg::*;
(
	input  wire logic         clk,
	input  wire logic         rst,
	input  wire logic         in_valid,
	input  wire alloc_grant_t in_data,
	output logic              in_ready,
	output logic              gnt_req,
	output alloc_grant_t      gnt_data,
	input  wire logic         gnt_ack
);

	typedef enum logic [1:0] {
		GNT_IDLE,     // Free for a new grant.
		GNT_REQ,      // Request high, waiting for ack.
		GNT_WAIT_REL  // Request dropped, waiting for ack low.
	} gnt_state_t;

	gnt_state_t   state;
	alloc_grant_t hold;

	assign in_ready = (state == GNT_IDLE);
	assign gnt_req  = (state == GNT_REQ);
	assign gnt_data = hold;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= GNT_IDLE;
		end else begin
			case (state)
				GNT_IDLE:
					if (in_valid)
						state <= GNT_REQ;
				GNT_REQ:
					if (gnt_ack)
						state <= GNT_WAIT_REL;
				GNT_WAIT_REL:
					if (!gnt_ack)
						state <= GNT_IDLE;
				default:
					state <= GNT_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			hold <= in_data; // Frozen until back in idle.
	end

	// Consumer acks only a pending request.
	ack_answers: assert property (@(posedge clk) disable iff (rst)
		$rose(gnt_ack) |-> gnt_req)
		else $error("gnt_ack rose while gnt_req was low");

endmodule

`default_nettype wire

//--- list.f
+incdir+.
alloc_pkg.sv
lzp.sv
req_sync_stage.sv
slot_pick_stage.sv
slot_table.sv
grant_stage.sv
slot_alloc_top.sv
tb_slot_alloc.sv

//--- lzp.sv
/* Lowest-zero search over an input of up to 128 bits.
   Gives the index of the least significant zero and all-ones / all-zeros flags. */

`timescale 1ns/1ps
`default_nettype none

module lzp #(
	parameter int CW = 4,
	parameter int DW = 2**CW
) (
	input  wire logic [DW-1:0] in_i,
	output logic [CW-1:0]      pos_o,
	output logic               all1,
	output logic               all0
);

	// Ones above DW so the padding never looks free.
	localparam logic [127:0] PAD = ~((128'd1 << DW) - 128'd1);

	// zero_any[l][i] is set when node i on level l covers at least one zero.
	// Level 7 is the leaf level, level 0 the root.
	wire [127:0] zero_any [0:7];
	// Set when the left child has no zero and the search goes right.
	wire [127:0] go_right [0:6];
	logic [6:0]  pos;

	assign zero_any[7] = ~(128'(in_i) | PAD); // One marks a zero bit.

	for (genvar l = 0; l < 7; l++) begin : g_level
		for (genvar i = 0; i < (1 << l); i++) begin : g_node
			assign zero_any[l][i] = zero_any[l+1][2*i] | zero_any[l+1][2*i+1];
			assign go_right[l][i] = ~zero_any[l+1][2*i];
		end
	end

	// Walk from the root, one index bit per level.
	always_comb begin
		pos = '0;
		for (int l = 0; l < 7; l++) begin
			pos = {pos[5:0], go_right[l][pos]}; // Prefix picks the node.
		end
	end

	assign pos_o = pos[CW-1:0];
	assign all1  = ~zero_any[0][0]; // No zero anywhere.
	assign all0  = ~|in_i;          // Every bit clear.

endmodule

`default_nettype wire

//--- req_sync_stage.sv
/* Four-phase slave for the host alloc port.
   Captures the owner into a one-entry buffer that feeds the slot picker. */

`timescale 1ns/1ps
`default_nettype none

`include "alloc_params.svh"

module req_sync_stage
	import alloc_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       alloc_req,
	input  wire alloc_req_t alloc_owner,
	output logic            alloc_ack,
	output logic            out_valid,
	output alloc_req_t      out_data,
	input  wire logic       out_ready
);

	logic capture;

	// Fresh request, old handshake finished and buffer free.
	assign capture = alloc_req && !alloc_ack && !out_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			alloc_ack <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			if (capture)
				alloc_ack <= 1'b1;
			else if (!alloc_req)
				alloc_ack <= 1'b0; // Host has let go.

			if (capture)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0; // Entry taken by the picker.
		end
	end

	always_ff @(posedge clk) begin
		if (capture)
			out_data <= alloc_owner; // Owner is stable while req is high.
	end

	// A new request must wait until the previous ack has fallen.
	req_after_ack: assert property (@(posedge clk) disable iff (rst)
		$rose(alloc_req) |-> !alloc_ack)
		else $error("alloc_req rose before alloc_ack fell");

endmodule

`default_nettype wire

//--- slot_alloc_top.sv
/* Top level of the tag allocator.
   Chains request sync, slot pick and grant stages, plus the owner table. */

`timescale 1ns/1ps
`default_nettype none

`include "alloc_params.svh"

module slot_alloc_top
	import alloc_pkg::*;
(
	input  wire logic         clk,
	input  wire logic         rst,
	input  wire logic         alloc_req,
	input  wire alloc_req_t   alloc_owner,
	output logic              alloc_ack,
	output logic              gnt_req,
	output alloc_grant_t      gnt_data,
	input  wire logic         gnt_ack,
	input  wire logic         rel_valid,
	input  wire slot_t        rel_slot,
	output logic              rel_owner_valid,
	output owner_t            rel_owner,
	output logic              all_busy,
	output logic              all_free
);

	logic         req_valid;  // Sync stage to picker.
	logic         req_ready;
	alloc_req_t   req_data;
	logic         pick_valid; // Picker to grant stage.
	logic         pick_ready;
	alloc_grant_t pick_data;
	logic         wr_en;      // Picker to owner table.
	slot_t        wr_slot;
	owner_t       wr_owner;

	req_sync_stage u_req_sync (
		.clk         (clk),
		.rst         (rst),
		.alloc_req   (alloc_req),
		.alloc_owner (alloc_owner),
		.alloc_ack   (alloc_ack),
		.out_valid   (req_valid),
		.out_data    (req_data),
		.out_ready   (req_ready)
	);

	slot_pick_stage u_slot_pick (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (req_valid),
		.in_data   (req_data),
		.in_ready  (req_ready),
		.out_valid (pick_valid),
		.out_data  (pick_data),
		.out_ready (pick_ready),
		.rel_valid (rel_valid),
		.rel_slot  (rel_slot),
		.wr_en     (wr_en),
		.wr_slot   (wr_slot),
		.wr_owner  (wr_owner),
		.all_busy  (all_busy),
		.all_free  (all_free)
	);

	// Release port reads the owner straight from the table.
	slot_table u_slot_table (
		.clk      (clk),
		.rst      (rst),
		.wr_en    (wr_en),
		.wr_slot  (wr_slot),
		.wr_owner (wr_owner),
		.rd_en    (rel_valid),
		.rd_slot  (rel_slot),
		.rd_owner (rel_owner),
		.rd_valid (rel_owner_valid)
	);

	grant_stage u_grant (
		.clk      (clk),
		.rst      (rst),
		.in_valid (pick_valid),
		.in_data  (pick_data),
		.in_ready (pick_ready),
		.gnt_req  (gnt_req),
		.gnt_data (gnt_data),
		.gnt_ack  (gnt_ack)
	);

endmodule

`default_nettype wire

//--- slot_pick_stage.sv
/* Occupancy bitmap and lowest-free pick for the tag pool.
   Allocates one slot per transfer, clears released slots and reports pool status. */

`timescale 1ns/1ps
`default_nettype none

`include "alloc_params.svh"

module slot_pick_stage
	import alloc_pkg::*;
(
	input  wire logic         clk,
	input  wire logic         rst,
	input  wire logic         in_valid,
	input  wire alloc_req_t   in_data,
	output logic              in_ready,
	output logic              out_valid,
	output alloc_grant_t      out_data,
	input  wire logic         out_ready,
	input  wire logic         rel_valid,
	input  wire slot_t        rel_slot,
	output logic              wr_en,
	output slot_t             wr_slot,
	output owner_t            wr_owner,
	output logic              all_busy,
	output logic              all_free
);

	logic [`ALLOC_SLOTS-1:0] busy_map; // One bit per slot, set when taken.
	logic [`ALLOC_SLOTS-1:0] set_mask;
	logic [`ALLOC_SLOTS-1:0] clr_mask;
	slot_t                   free_slot;
	logic                    alloc_fire;

	lzp #(
		.CW (`ALLOC_CW),
		.DW (`ALLOC_SLOTS)
	) u_lzp (
		.in_i  (busy_map),
		.pos_o (free_slot),
		.all1  (all_busy),
		.all0  (all_free)
	);

	// Stall the request while the pool is full.
	assign out_valid  = in_valid && !all_busy;
	assign in_ready   = out_ready && !all_busy;
	assign alloc_fire = in_valid && in_ready;

	assign out_data.slot  = free_slot;
	assign out_data.owner = in_data.owner;

	assign wr_en    = alloc_fire;
	assign wr_slot  = free_slot;
	assign wr_owner = in_data.owner;

	assign set_mask = {{(`ALLOC_SLOTS-1){1'b0}}, alloc_fire} << free_slot;
	assign clr_mask = {{(`ALLOC_SLOTS-1){1'b0}}, rel_valid} << rel_slot;

	// Pick and release never hit the same slot, so order does not matter.
	always_ff @(posedge clk) begin
		if (rst)
			busy_map <= '0;
		else
			busy_map <= (busy_map | set_mask) & ~clr_mask;
	end

	// Host may only release a slot it holds.
	rel_busy: assert property (@(posedge clk) disable iff (rst)
		rel_valid |-> busy_map[rel_slot])
		else $error("release of free slot %0d", rel_slot);

	// The lzp pick must land on a free slot.
	pick_free: assert property (@(posedge clk) disable iff (rst)
		alloc_fire |-> !busy_map[free_slot])
		else $error("allocated slot was not free");

endmodule

`default_nettype wire

//--- slot_table.sv
/* Per-slot owner storage.
   Written on allocation, read one cycle after a release request. */

`timescale 1ns/1ps
`default_nettype none

`include "alloc_params.svh"

module slot_table
	import alloc_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   rst,
	input  wire logic   wr_en,
	input  wire slot_t  wr_slot,
	input  wire owner_t wr_owner,
	input  wire logic   rd_en,
	input  wire slot_t  rd_slot,
	output owner_t      rd_owner,
	output logic        rd_valid
);

	owner_t owner_mem [`ALLOC_SLOTS]; // Owner of each busy slot.

	always_ff @(posedge clk) begin
		if (wr_en)
			owner_mem[wr_slot] <= wr_owner;
		if (rd_en)
			rd_owner <= owner_mem[rd_slot]; // Registered read port.
	end

	always_ff @(posedge clk) begin
		if (rst)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_en;
	end

endmodule

`default_nettype wire

//--- tb_slot_alloc.sv
/* Testbench for the tag allocator top level.
   Runs fill, back-pressure, random mix and drain phases against a shadow bitmap.
   Concurrent assertions compare the grant and release ports with the model. */

`timescale 1ns/1ps
`default_nettype none

`include "alloc_params.svh"

module tb_slot_alloc
	import alloc_pkg::*;
();

	localparam logic [31:0] SEED = 32'hac426202;
	localparam int N_OPS = 233; // Fill, back-pressure, random mix and drain.

	logic         clk;
	logic         rst;
	logic         alloc_req;
	alloc_req_t   alloc_owner;
	logic         alloc_ack;
	logic         gnt_req;
	alloc_grant_t gnt_data;
	logic         gnt_ack;
	logic         rel_valid;
	slot_t        rel_slot;
	logic         rel_owner_valid;
	owner_t       rel_owner;
	logic         all_busy;
	logic         all_free;

	// Shadow model of the pool.
	logic [`ALLOC_SLOTS-1:0] model_map;
	logic [`ALLOC_SLOTS-1:0] status_map; // Model as the DUT bitmap sees it.
	owner_t                  model_owner [`ALLOC_SLOTS];
	owner_t                  pend_owner;  // Owner of the request in flight.
	owner_t                  exp_rel_owner;
	slot_t                   exp_slot;
	logic                    gnt_prev;
	logic                    gnt_rose;
	int                      grant_count;
	logic [31:0]             main_lfsr;
	logic [31:0]             ack_lfsr;

	slot_alloc_top u_dut (
		.clk             (clk),
		.rst             (rst),
		.alloc_req       (alloc_req),
		.alloc_owner     (alloc_owner),
		.alloc_ack       (alloc_ack),
		.gnt_req         (gnt_req),
		.gnt_data        (gnt_data),
		.gnt_ack         (gnt_ack),
		.rel_valid       (rel_valid),
		.rel_slot        (rel_slot),
		.rel_owner_valid (rel_owner_valid),
		.rel_owner       (rel_owner),
		.all_busy        (all_busy),
		.all_free        (all_free)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Fibonacci LFSR, taps 32 22 2 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic draw(inout logic [31:0] st, input int nbits, output int val);
		val = 0;
		for (int i = 0; i < nbits; i++) begin
			st = lfsr_next(st);
			val = (val << 1) | int'(st[0]); // One step per bit.
		end
	endtask

	function automatic slot_t lowest_clear(input logic [`ALLOC_SLOTS-1:0] map);
		for (int i = 0; i < `ALLOC_SLOTS; i++) begin
			if (!map[i])
				return slot_t'(i);
		end
		return '0;
	endfunction

	task automatic fail_now(input string msg);
		$display("mismatch at %0t ns: %s", $time, msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	assign gnt_rose = gnt_req && !gnt_prev;

	always_comb begin
		exp_slot   = lowest_clear(model_map);
		status_map = model_map;
		if (gnt_rose)
			status_map[exp_slot] = 1'b1; // DUT marks the slot one edge earlier.
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			model_map   <= '0;
			grant_count <= 0;
			gnt_prev    <= 1'b0;
		end else begin
			gnt_prev <= gnt_req;
			if (gnt_rose) begin
				model_map[exp_slot]   <= 1'b1;
				model_owner[exp_slot] <= pend_owner;
				grant_count           <= grant_count + 1;
			end
			if (rel_valid) begin
				model_map[rel_slot] <= 1'b0;
				exp_rel_owner       <= model_owner[rel_slot];
			end
		end
	end

	grant_slot: assert property (@(posedge clk) disable iff (rst)
		gnt_rose |-> gnt_data.slot == exp_slot)
		else fail_now($sformatf("grant slot %0d, expected %0d",
			$sampled(gnt_data.slot), $sampled(exp_slot)));
	grant_owner: assert property (@(posedge clk) disable iff (rst)
		gnt_rose |-> gnt_data.owner == pend_owner)
		else fail_now("grant owner differs from requesting owner");
	grant_not_full: assert property (@(posedge clk) disable iff (rst)
		gnt_rose |-> !(&model_map))
		else fail_now("grant issued while every slot was busy");
	status_free: assert property (@(posedge clk) disable iff (rst)
		all_free == (status_map == '0))
		else fail_now("all_free disagrees with the model bitmap");
	status_busy: assert property (@(posedge clk) disable iff (rst)
		all_busy == (&status_map))
		else fail_now("all_busy disagrees with the model bitmap");
	rel_owner_ok: assert property (@(posedge clk) disable iff (rst)
		rel_valid |=> rel_owner_valid && rel_owner == exp_rel_owner)
		else fail_now("release did not return the stored owner");
	rel_valid_only: assert property (@(posedge clk) disable iff (rst)
		rel_owner_valid |-> $past(rel_valid))
		else fail_now("rel_owner_valid without a release");
	ack_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(alloc_ack) |-> $past(alloc_req))
		else fail_now("alloc_ack rose without alloc_req");
	ack_fall: assert property (@(posedge clk) disable iff (rst)
		$fell(alloc_ack) |-> !$past(alloc_req))
		else fail_now("alloc_ack fell while alloc_req was high");
	greq_rise: assert property (@(posedge clk) disable iff (rst)
		gnt_rose |-> !$past(gnt_ack))
		else fail_now("gnt_req rose while gnt_ack was high");
	greq_fall: assert property (@(posedge clk) disable iff (rst)
		$fell(gnt_req) |-> $past(gnt_ack))
		else fail_now("gnt_req fell before gnt_ack");
	gnt_hold: assert property (@(posedge clk) disable iff (rst)
		gnt_req && gnt_prev |-> $stable(gnt_data))
		else fail_now("gnt_data changed during the request phase");

	// Full alloc handshake, then wait for the matching grant.
	task automatic do_alloc(input owner_t own);
		int start;
		start = grant_count;
		@(posedge clk);
		alloc_owner.owner <= own;
		alloc_req         <= 1'b1;
		pend_owner        <= own;
		do begin
			@(posedge clk);
		end while (!alloc_ack);
		alloc_req <= 1'b0;
		do begin
			@(posedge clk);
		end while (alloc_ack);
		while (grant_count == start)
			@(posedge clk);
	endtask

	task automatic do_release(input slot_t s);
		@(posedge clk);
		rel_valid <= 1'b1;
		rel_slot  <= s;
		@(posedge clk);
		rel_valid <= 1'b0;
		@(posedge clk); // Model and owner check settle here.
	endtask

	task automatic release_random();
		int    start;
		slot_t rs;
		draw(main_lfsr, `ALLOC_CW, start);
		rs = slot_t'(start);
		while (!model_map[rs])
			rs = rs + 1'b1; // Wraps around the pool.
		do_release(rs);
	endtask

	initial begin : grant_responder
		int delay;
		ack_lfsr = SEED;
		forever begin
			@(posedge clk);
			if (!rst && gnt_req) begin
				draw(ack_lfsr, 3, delay);
				repeat (delay) @(posedge clk);
				gnt_ack <= 1'b1;
				do begin
					@(posedge clk);
				end while (gnt_req);
				gnt_ack <= 1'b0;
			end
		end
	end

	initial begin : watchdog
		repeat (N_OPS * 400) @(posedge clk);
		$display("Watchdog expired: run did not finish within %0d cycles", N_OPS * 400);
		$display("Test failures found");
		$fatal(1);
	end

	initial begin : main_seq
		int own;
		int k;
		int op;
		rst         = 1'b1;
		alloc_req   = 1'b0;
		alloc_owner = '0;
		gnt_ack     = 1'b0;
		rel_valid   = 1'b0;
		rel_slot    = '0;
		main_lfsr   = SEED;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		repeat (2) @(posedge clk);

		// Fill the pool from empty.
		for (int i = 0; i < `ALLOC_SLOTS; i++) begin
			draw(main_lfsr, `ALLOC_OWNER_W, own);
			do_alloc(owner_t'(own));
		end
		fill_busy: assert (all_busy)
			else fail_now("pool not reported full after the fill");

		// One request waits on a full pool until a release.
		draw(main_lfsr, `ALLOC_OWNER_W, own);
		draw(main_lfsr, `ALLOC_CW, k);
		fork
			do_alloc(owner_t'(own));
			begin
				repeat (20) @(posedge clk);
				do_release(slot_t'(k));
			end
		join

		for (int n = 0; n < 200; n++) begin
			draw(main_lfsr, 1, op);
			if (model_map == '0 || (op == 0 && !(&model_map))) begin
				draw(main_lfsr, `ALLOC_OWNER_W, own);
				do_alloc(owner_t'(own));
			end else begin
				release_random();
			end
		end

		// Drain.
		for (int i = 0; i < `ALLOC_SLOTS; i++) begin
			if (model_map[i])
				do_release(slot_t'(i));
		end
		drain_free: assert (all_free)
			else fail_now("pool not reported free after the drain");

		repeat (4) @(posedge clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire
